// ==== src/rom_defs.svh ====
/*
 * Shared width macros for the one-slot ROM port.
 * SDRAM halfword address and read word widths,
 * and the default client data and address widths of a slot.
 */
`ifndef ROM_DEFS_SVH
`define ROM_DEFS_SVH

// The SDRAM is addressed in 16-bit halfwords.
// 22 bits cover 8 MB of ROM data.
`define SDRAM_AW 22

// One SDRAM read returns two consecutive halfwords.
// That word is exactly one cache line of the slot.
`define SDRAM_DW 32

// Client item width in bits when the top is not overridden.
// Legal values are 8, 16 and 32.
`define SLOT_DW_DEFAULT 8

// Client address width in bits, counted in items of SLOT_DW_DEFAULT bits.
`define SLOT_AW_DEFAULT 8

`endif

// ==== src/sdram_pkg.sv ====
/*
 * Types for the SDRAM side of the ROM port.
 * Halfword address type, 32-bit read word type
 * and the states of the line fetch FSM.
 */
`default_nettype none
`include "rom_defs.svh"

package sdram_pkg;

    // Halfword address as seen by the SDRAM controller.
    typedef logic [`SDRAM_AW-1:0] sdram_addr_t;

    // One read word from the controller.
    // The lower halfword sits at the requested address, the upper one at the next.
    typedef logic [`SDRAM_DW-1:0] sdram_word_t;

    // Line fetch sequence.
    // The request level is held in wait_ack.
    // The data pulse is awaited in wait_data.
    typedef enum logic [1:0] {
        idle      = 2'd0, // No fetch in flight.
        wait_ack  = 2'd1, // sdram_req is high until the controller acknowledges.
        wait_data = 2'd2  // Request accepted, waiting for the data_rdy pulse.
    } fetch_state_e;

endpackage

`default_nettype wire

// ==== src/rom_slot_pkg.sv ====
/*
 * Types for the client side of the ROM port.
 * The lookup opcode passed from decode to the fetch stage
 * and the byte lane index inside a cache line.
 */
`default_nettype none
`include "rom_defs.svh"

package rom_slot_pkg;

    // Result of the line lookup for the current client request.
    // Only the decode stage works out hit or miss.
    // The fetch stage reacts to this code alone.
    typedef enum logic [1:0] {
        op_idle  = 2'd0, // Chip select is low.
        op_hit   = 2'd1, // Line valid and tag equal.
        op_fetch = 2'd2  // Miss, the line must be read from SDRAM.
    } lookup_op_e;

    // Byte position of the item inside the 4-byte line.
    // 16-bit items use positions 0 and 2 only.
    // 32-bit items always use position 0.
    typedef logic [1:0] lane_t;

endpackage

`default_nettype wire

// ==== src/rom_slot_decode.sv ====
/*
 * Line lookup stage of the one-slot ROM port.
 * Turns the client item address into an SDRAM line address and a byte lane,
 * keeps the tag and valid flag of the cached line
 * and issues the lookup opcode for the fetch stage.
 */
`default_nettype none
`include "rom_defs.svh"

module rom_slot_decode
    import sdram_pkg::*, rom_slot_pkg::*;
#(
    parameter int DW = `SLOT_DW_DEFAULT, // Item width, 8, 16 or 32.
    parameter int AW = `SLOT_AW_DEFAULT  // Item address width.
) (
    input  logic          rst,
    input  logic          clk,
    input  logic [AW-1:0] addr,       // Client item address.
    input  logic          cs,         // Request level from the client.
    input  sdram_addr_t   offset,     // Base of the ROM region in SDRAM.
    input  logic          fill_pulse, // A new line has just been captured.
    output lookup_op_e    lookup_op,
    output sdram_addr_t   line_addr,  // Halfword address of the requested line.
    output logic          hit,
    output lane_t         lane
);

    // Shift from item address to byte address.
    localparam int SH = $clog2(DW / 8);
    // Two extra bits hold the byte address of a 32-bit item.
    localparam int BW = AW + 2;

    logic [BW-1:0] byte_addr; // Byte address of the requested item.
    logic [AW-1:0] line_idx;  // Index of the 4-byte line.
    sdram_addr_t   tag;       // Line address of the cached line, offset included.
    logic          valid;     // The line register holds real data.

    // Scale the item address to bytes.
    assign byte_addr = {2'b00, addr} << SH;
    assign line_idx  = byte_addr[BW-1:2]; // Four bytes per line.
    assign lane      = byte_addr[1:0];    // Byte position inside the line.

    // Each line spans two halfwords in SDRAM.
    // The offset is added in halfword units.
    assign line_addr = offset + (sdram_addr_t'(line_idx) << 1);

    // The tag carries the offset too.
    // A new offset on the same item address therefore misses.
    assign hit = cs && valid && (tag == line_addr);

    always_comb begin
        if (!cs) begin
            lookup_op = op_idle; // Nothing requested.
        end else if (hit) begin
            lookup_op = op_hit;
        end else begin
            lookup_op = op_fetch; // Fetch stage starts a read if it is free.
        end
    end

    // Valid is control state and comes out of reset cleared.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (fill_pulse) begin
            valid <= 1'b1; // Stays set, later fills only replace the tag.
        end
    end

    // The client holds its address during a miss.
    // The current line address is therefore the one just fetched.
    always_ff @(posedge clk) begin
        if (fill_pulse) begin
            tag <= line_addr;
        end
    end

endmodule

`default_nettype wire

// ==== src/rom_slot_fetch.sv ====
/*
 * Execute stage of the one-slot ROM port.
 * An FSM that requests one line from the SDRAM controller,
 * holds the request level until the acknowledge,
 * captures the read word on the data_rdy pulse and signals the fill.
 */
`default_nettype none
`include "rom_defs.svh"

module rom_slot_fetch
    import sdram_pkg::*, rom_slot_pkg::*;
(
    input  logic        rst,
    input  logic        clk,
    input  lookup_op_e  lookup_op,  // Opcode from the decode stage.
    input  sdram_addr_t line_addr,  // Line to read when the opcode is op_fetch.
    input  logic        sdram_ack,  // Controller has taken the request.
    input  logic        data_rdy,   // One-cycle pulse with valid data_read.
    input  sdram_word_t data_read,
    output logic        sdram_req,  // Level, held until sdram_ack.
    output sdram_addr_t sdram_addr,
    output sdram_word_t line_data,  // The cached line.
    output logic        fill_pulse  // High in the cycle the line is written.
);

    fetch_state_e state;
    logic         start;   // A new read begins this cycle.
    logic         capture; // data_read belongs to our request this cycle.

    // Only one line is in flight, so a miss seen while busy waits.
    assign start = (state == idle) && (lookup_op == op_fetch);

    // The data pulse counts only once the request has been accepted.
    // It may come in the same cycle as the acknowledge.
    assign capture = data_rdy && ((state == wait_data) || ((state == wait_ack) && sdram_ack));

    assign sdram_req  = (state == wait_ack); // Straight from the state register.
    assign fill_pulse = capture;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= wait_ack;
                    end
                end
                wait_ack: begin
                    // The request drops in the cycle after the acknowledge is sampled.
                    if (sdram_ack) begin
                        state <= capture ? idle : wait_data;
                    end
                end
                wait_data: begin
                    // A late data pulse simply keeps the FSM here.
                    if (capture) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // The address is latched at the start of the request.
    // It then stays stable while sdram_req is high.
    always_ff @(posedge clk) begin
        if (start) begin
            sdram_addr <= line_addr;
        end
    end

    // The line register only changes on a fill.
    always_ff @(posedge clk) begin
        if (capture) begin
            line_data <= data_read;
        end
    end

endmodule

`default_nettype wire

// ==== src/rom_slot_lane.sv ====
/*
 * Result stage of the one-slot ROM port.
 * Picks the requested 8, 16 or 32-bit item out of the cached line
 * and registers it with the ok flag, once or twice depending on REPACK.
 */
`default_nettype none
`include "rom_defs.svh"

module rom_slot_lane
    import sdram_pkg::*, rom_slot_pkg::*;
#(
    parameter int DW     = `SLOT_DW_DEFAULT, // Item width, 8, 16 or 32.
    parameter int REPACK = 0                 // 1 adds a second output stage.
) (
    input  logic          rst,
    input  logic          clk,
    input  sdram_word_t   line_data,
    input  lane_t         lane,
    input  logic          hit,
    output logic [DW-1:0] dout,
    output logic          data_ok
);

    sdram_word_t   shifted;   // Line moved down so the item starts at bit 0.
    logic [DW-1:0] lane_data; // The selected item.
    logic [DW-1:0] dout_q;
    logic          ok_q;

    // Wider items take the bytes above their lane.
    // Aligned addresses keep them inside the line.
    assign shifted   = line_data >> {lane, 3'b000};
    assign lane_data = shifted[DW-1:0];

    // First stage, the ok flag follows hit one cycle later.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ok_q <= 1'b0;
        end else begin
            ok_q <= hit;
        end
    end

    // Data only loads on a hit, so dout holds the last good item otherwise.
    always_ff @(posedge clk) begin
        if (hit) begin
            dout_q <= lane_data;
        end
    end

    generate
        if (REPACK == 1) begin : g_repack
            logic [DW-1:0] dout_r;
            logic          ok_r;

            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    ok_r <= 1'b0;
                end else begin
                    ok_r <= ok_q; // One more cycle of latency.
                end
            end

            always_ff @(posedge clk) begin
                dout_r <= dout_q;
            end

            assign dout    = dout_r;
            assign data_ok = ok_r;
        end else begin : g_direct
            assign dout    = dout_q;
            assign data_ok = ok_q;
        end
    endgenerate

endmodule

`default_nettype wire

// ==== src/rom_1slot.sv ====
/*
 * One-slot read-only ROM port on SDRAM.
 * A 4-byte line cache serving 8, 16 or 32-bit items to one client.
 * Decode finds the line, fetch reads it from SDRAM on a miss,
 * lane selects and registers the item.
 */
`default_nettype none
`include "rom_defs.svh"

module rom_1slot
    import sdram_pkg::*, rom_slot_pkg::*;
#(
    parameter int DW     = `SLOT_DW_DEFAULT, // Item width, 8, 16 or 32.
    parameter int AW     = `SLOT_AW_DEFAULT, // Item address width.
    parameter int REPACK = 0                 // 1 registers the output once more.
) (
    input  logic          rst,
    input  logic          clk,
    input  logic [AW-1:0] slot0_addr,
    output logic [DW-1:0] slot0_dout,
    input  logic          slot0_cs,     // Held high for the whole access.
    input  sdram_addr_t   slot0_offset, // Region base in halfwords.
    output logic          slot0_ok,
    input  logic          sdram_ack,
    output logic          sdram_req,
    output sdram_addr_t   sdram_addr,
    input  logic          data_rdy,
    input  sdram_word_t   data_read
);

    lookup_op_e  lookup_op;  // Decode to fetch.
    sdram_addr_t line_addr;
    logic        fill_pulse; // Fetch back to decode.
    sdram_word_t line_data;  // Fetch to lane.
    logic        hit;        // Decode to lane.
    lane_t       lane;

    rom_slot_decode #(
        .DW (DW),
        .AW (AW)
    ) u_decode (
        .rst        (rst),
        .clk        (clk),
        .addr       (slot0_addr),
        .cs         (slot0_cs),
        .offset     (slot0_offset),
        .fill_pulse (fill_pulse),
        .lookup_op  (lookup_op),
        .line_addr  (line_addr),
        .hit        (hit),
        .lane       (lane)
    );

    rom_slot_fetch u_fetch (
        .rst        (rst),
        .clk        (clk),
        .lookup_op  (lookup_op),
        .line_addr  (line_addr),
        .sdram_ack  (sdram_ack),
        .data_rdy   (data_rdy),
        .data_read  (data_read),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .line_data  (line_data),
        .fill_pulse (fill_pulse)
    );

    rom_slot_lane #(
        .DW     (DW),
        .REPACK (REPACK)
    ) u_lane (
        .rst       (rst),
        .clk       (clk),
        .line_data (line_data),
        .lane      (lane),
        .hit       (hit),
        .dout      (slot0_dout),
        .data_ok   (slot0_ok)
    );

endmodule

`default_nettype wire

// ==== tests/sdram_rom_model.sv ====
/*
 * Behavioral SDRAM controller for the ROM port testbench.
 * Acknowledges each request and returns the data word after
 * random delays of 0 to 5 cycles drawn from a seeded $random.
 */
`default_nettype none

module sdram_rom_model
    import sdram_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h8ab0_c91b // Start value of the delay generator.
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        sdram_req,
    input  sdram_addr_t sdram_addr,
    output logic        sdram_ack,
    output logic        data_rdy,
    output sdram_word_t data_read
);

    integer seed; // State of the delay generator.

    // ROM content, the halfword at h holds h XOR 5a3c in its low 16 bits.
    function automatic logic [15:0] rom_halfword(input sdram_addr_t h);
        return h[15:0] ^ 16'h5a3c;
    endfunction

    // Delay of 0 to 5 cycles.
    function automatic int draw_delay();
        return $unsigned($random(seed)) % 6;
    endfunction

    // One full request, ack pulse first, then the data pulse.
    task automatic serve_request();
        sdram_addr_t a;
        int          ack_delay;
        int          data_delay;
        a          = sdram_addr; // Address is stable while the request is held.
        ack_delay  = draw_delay();
        data_delay = draw_delay();
        repeat (ack_delay) begin
            @(posedge clk);
            #10;
        end
        sdram_ack = 1'b1;
        @(posedge clk);
        #10;
        sdram_ack = 1'b0;
        repeat (data_delay) begin
            @(posedge clk);
            #10;
        end
        data_rdy  = 1'b1;
        data_read = {rom_halfword(a + 1'b1), rom_halfword(a)}; // Next halfword on top.
        @(posedge clk);
        #10;
        data_rdy = 1'b0; // Single-cycle pulse.
    endtask

    initial begin
        seed      = SEED;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            #10; // Outputs change away from the clock edge, like the client inputs.
            if (!rst && sdram_req) begin
                serve_request();
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/rom_1slot_checker.sv ====
/*
 * Concurrent assertions for the ROM port, bound into rom_1slot.
 * Request level held until ack, stable request address,
 * and the control state right after reset.
 */
`default_nettype none

module rom_1slot_checker
    import sdram_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input logic         sdram_req,
    input logic         sdram_ack,
    input sdram_addr_t  sdram_addr,
    input logic         slot0_ok,
    input fetch_state_e fetch_state // State register of the fetch FSM.
);

    int failures = 0; // Read by the testbench at the end of the run.

    // The request level only drops once the ack has been sampled.
    req_held: assert property (@(posedge clk) disable iff (rst)
        sdram_req && !sdram_ack |=> sdram_req)
        else begin
            failures++;
            $error("sdram_req dropped before sdram_ack");
        end

    // The controller may latch the address at any point of the request.
    addr_stable: assert property (@(posedge clk) disable iff (rst)
        sdram_req |=> !sdram_req || $stable(sdram_addr))
        else begin
            failures++;
            $error("sdram_addr changed while sdram_req was high");
        end

    // Leaving reset, nothing is requested and nothing is reported ok.
    reset_state: assert property (@(posedge clk)
        $fell(rst) |-> !sdram_req && !slot0_ok && (fetch_state == idle))
        else begin
            failures++;
            $error("control outputs not in reset state after rst fell");
        end

endmodule

bind rom_1slot rom_1slot_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .sdram_req   (sdram_req),
    .sdram_ack   (sdram_ack),
    .sdram_addr  (sdram_addr),
    .slot0_ok    (slot0_ok),
    .fetch_state (u_fetch.state)
);

`default_nettype wire

// ==== tests/rom_1slot_tb.sv ====
/*
 * Testbench for the one-slot ROM port with 16-bit items.
 * Clock, reset, the SDRAM model, a request monitor,
 * the stimulus table applied in a loop, compare tasks and the final report.
 */
`default_nettype none

module rom_1slot_tb
    import sdram_pkg::*;
;

    localparam int DW         = 16;
    localparam int AW         = 8;
    localparam int REPACK     = 0;
    localparam int NUM_ROWS   = 14;
    localparam int OK_TIMEOUT = 50; // Cycles allowed for slot0_ok to rise.
    localparam int DROP_LIMIT = 2;  // Cycles allowed for slot0_ok to fall.

    logic          clk;
    logic          rst;
    logic [AW-1:0] slot0_addr;
    logic [DW-1:0] slot0_dout;
    logic          slot0_cs;
    sdram_addr_t   slot0_offset;
    logic          slot0_ok;
    logic          sdram_ack;
    logic          sdram_req;
    sdram_addr_t   sdram_addr;
    logic          data_rdy;
    sdram_word_t   data_read;

    logic [AW-1:0] tab_addr   [NUM_ROWS]; // Client item address.
    sdram_addr_t   tab_offset [NUM_ROWS]; // Region base in halfwords.
    bit            tab_fetch  [NUM_ROWS]; // 1 when the row must read SDRAM.

    int          errors    = 0;
    int          checks    = 0;
    int          req_count = 0; // Requests seen since reset.
    logic        req_prev  = 1'b0;
    sdram_addr_t last_req_addr;

    rom_1slot #(
        .DW     (DW),
        .AW     (AW),
        .REPACK (REPACK)
    ) dut (
        .rst          (rst),
        .clk          (clk),
        .slot0_addr   (slot0_addr),
        .slot0_dout   (slot0_dout),
        .slot0_cs     (slot0_cs),
        .slot0_offset (slot0_offset),
        .slot0_ok     (slot0_ok),
        .sdram_ack    (sdram_ack),
        .sdram_req    (sdram_req),
        .sdram_addr   (sdram_addr),
        .data_rdy     (data_rdy),
        .data_read    (data_read)
    );

    sdram_rom_model #(
        .SEED (32'h8ab0_c91b)
    ) u_sdram (
        .clk        (clk),
        .rst        (rst),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .sdram_ack  (sdram_ack),
        .data_rdy   (data_rdy),
        .data_read  (data_read)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // Period of 100.
    end

    // Count each new request and keep the address it carried.
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            req_prev = 1'b0;
        end else begin
            if (sdram_req && !req_prev) begin
                req_count     = req_count + 1;
                last_req_addr = sdram_addr; // Latched by the DUT when the request began.
            end
            req_prev = sdram_req;
        end
    end

    task automatic set_row(input int i, input logic [AW-1:0] a, input sdram_addr_t off,
                           input bit fetch);
        tab_addr[i]   = a;
        tab_offset[i] = off;
        tab_fetch[i]  = fetch;
    endtask

    task automatic load_table();
        set_row(0,  8'h10, 22'h00_0000, 1'b1); // First access misses.
        set_row(1,  8'h11, 22'h00_0000, 1'b0); // Upper lane of the same line.
        set_row(2,  8'h10, 22'h00_0000, 1'b0); // Back to the lower lane after a cs drop.
        set_row(3,  8'h24, 22'h00_0000, 1'b1); // Different line.
        set_row(4,  8'h25, 22'h00_0000, 1'b0);
        set_row(5,  8'h25, 22'h01_0040, 1'b1); // New offset, same address.
        set_row(6,  8'h24, 22'h01_0040, 1'b0);
        set_row(7,  8'h10, 22'h01_0040, 1'b1);
        set_row(8,  8'hff, 22'h3f_ff00, 1'b1); // Top of the address space.
        set_row(9,  8'hfe, 22'h3f_ff00, 1'b0);
        set_row(10, 8'h10, 22'h00_0003, 1'b1); // Odd halfword offset.
        set_row(11, 8'h11, 22'h00_0003, 1'b0);
        set_row(12, 8'h80, 22'h00_0000, 1'b1);
        set_row(13, 8'h00, 22'h00_0000, 1'b1);
    endtask

    // ROM content as the controller returns it.
    function automatic logic [15:0] halfword_value(input sdram_addr_t h);
        return h[15:0] ^ 16'h5a3c;
    endfunction

    // Byte address is addr times DW/8. A line holds four bytes in two halfwords.
    function automatic sdram_addr_t expected_line_addr(input logic [AW-1:0] a,
                                                       input sdram_addr_t off);
        int byte_addr;
        byte_addr = int'(a) * (DW / 8);
        return off + sdram_addr_t'(byte_addr / 4) * 2;
    endfunction

    function automatic logic [DW-1:0] expected_dout(input logic [AW-1:0] a,
                                                    input sdram_addr_t off);
        int          byte_addr;
        sdram_addr_t hw;
        sdram_word_t line;
        byte_addr = int'(a) * (DW / 8);
        hw        = expected_line_addr(a, off);
        line      = {halfword_value(hw + 1'b1), halfword_value(hw)};
        return line[(byte_addr % 4) * 8 +: DW]; // Item starts at its byte lane.
    endfunction

    task automatic check_dout(input logic [DW-1:0] got, input logic [DW-1:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("** Error: slot0_dout got 0x%04h expected 0x%04h", got, expected);
        end
    endtask

    task automatic check_addr(input sdram_addr_t got, input sdram_addr_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("** Error: sdram_addr got 0x%06h expected 0x%06h", got, expected);
        end
    endtask

    task automatic check_requests(input int got, input int expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("** Error: sdram_req count got 0x%0h expected 0x%0h", got, expected);
        end
    endtask

    // Drop cs for at least one cycle and see slot0_ok follow.
    task automatic drop_cs(input int row);
        int cycles;
        slot0_cs = 1'b0;
        cycles   = 0;
        while (cycles == 0 || (slot0_ok && cycles < DROP_LIMIT)) begin
            @(posedge clk);
            #10;
            cycles++;
        end
        checks++;
        if (slot0_ok) begin
            errors++;
            $display("test %0d: slot0_ok still high two cycles after cs fell", row);
        end
    endtask

    task automatic wait_for_ok(output bit ok_seen);
        int cycles;
        ok_seen = 1'b0;
        for (cycles = 0; cycles < OK_TIMEOUT && !ok_seen; cycles++) begin
            @(posedge clk);
            #10; // Registered outputs have settled here.
            ok_seen = slot0_ok;
        end
    endtask

    task automatic run_row(input int row);
        int            start_errors;
        int            start_reqs;
        bit            ok_seen;
        sdram_addr_t   exp_addr;
        logic [DW-1:0] exp_dout;
        start_errors = errors;
        exp_addr     = expected_line_addr(tab_addr[row], tab_offset[row]);
        exp_dout     = expected_dout(tab_addr[row], tab_offset[row]);
        drop_cs(row);
        slot0_addr   = tab_addr[row];
        slot0_offset = tab_offset[row];
        slot0_cs     = 1'b1; // Held until the next row.
        start_reqs   = req_count;
        wait_for_ok(ok_seen);
        if (!ok_seen) begin
            errors++;
            $display("test %0d: slot0_ok did not rise within %0d cycles", row, OK_TIMEOUT);
        end else begin
            check_dout(slot0_dout, exp_dout);
            check_requests(req_count - start_reqs, tab_fetch[row] ? 1 : 0);
            if (tab_fetch[row] && req_count != start_reqs) begin
                check_addr(last_req_addr, exp_addr);
            end
        end
        $display("test %0d addr 0x%02h offset 0x%06h %s", row, tab_addr[row],
                 tab_offset[row], (errors == start_errors) ? "ok" : "FAILED");
    endtask

    initial begin : main
        int row;
        rst          = 1'b1;
        slot0_cs     = 1'b0;
        slot0_addr   = '0;
        slot0_offset = '0;
        load_table();
        repeat (10) @(posedge clk);
        #10;
        rst = 1'b0;
        for (row = 0; row < NUM_ROWS; row++) begin
            run_row(row);
        end
        slot0_cs = 1'b0;
        repeat (2) @(posedge clk);
        if (dut.u_checker.failures != 0) begin
            errors += dut.u_checker.failures;
            $display("protocol assertions failed %0d times", dut.u_checker.failures);
        end
        $display("%0d tests, %0d checks, %0d errors, %0d requests", NUM_ROWS, checks,
                 errors, req_count);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+src
src/sdram_pkg.sv
src/rom_slot_pkg.sv
src/rom_slot_decode.sv
src/rom_slot_fetch.sv
src/rom_slot_lane.sv
src/rom_1slot.sv
tests/sdram_rom_model.sv
tests/rom_1slot_checker.sv
tests/rom_1slot_tb.sv
